//--- verilog/cpu_isa_pkg.sv
// instruction set encodings, imported by the decoder, ALU, register file and sequencer
package cpu_isa_pkg;

	// kept 6809 opcodes, page 0 only
	typedef enum logic [7:0] {
		NOP  = 8'h12,
		BRA  = 8'h20,
		BNE  = 8'h26,
		BEQ  = 8'h27,
		SUBA = 8'h80,
		ANDA = 8'h84,
		LDA  = 8'h86,
		EORA = 8'h88,
		ORA  = 8'h8A,
		ADDA = 8'h8B,
		STA  = 8'h97,
		LDB  = 8'hC6,
		ADDB = 8'hCB,
		STB  = 8'hD7
	} opcode_e;

	typedef enum logic [1:0] {
		INHERENT,
		IMMEDIATE,
		DIRECT,     // operand byte is a page-zero address
		REL8        // operand byte is a signed pc offset
	} addr_mode_e;

	typedef enum logic [2:0] {
		ALU_LD,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_EOR
	} alu_op_e;

	typedef enum logic {
		ACC_A,
		ACC_B
	} acc_sel_e;

	typedef enum logic [1:0] {
		BR_NONE,
		BR_ALWAYS,
		BR_EQ,
		BR_NE
	} branch_e;

	// bit positions in the nzvc condition code
	localparam int FLAG_C = 0;
	localparam int FLAG_V = 1;
	localparam int FLAG_Z = 2;
	localparam int FLAG_N = 3;

	localparam logic [15:0] RESET_VECTOR = 16'hFFFE;  // high byte, low byte follows

endpackage

//--- verilog/cpu_bus_pkg.sv
// memory bus widths and transfer kinds, imported by the core and its units
package cpu_bus_pkg;

	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;

	// what a read returns, so the sequencer knows where to put it
	typedef enum logic [1:0] {
		BUS_FETCH,
		BUS_OPERAND,
		BUS_VECTOR,
		BUS_STORE
	} bus_kind_e;

endpackage

//--- verilog/opcode_decoder.sv
// combinational decode of the latched opcode into controls for the sequencer and datapath
module opcode_decoder (
	input  cpu_bus_pkg::data_t      opcode_i,
	output cpu_isa_pkg::addr_mode_e mode_o,
	output cpu_isa_pkg::alu_op_e    alu_op_o,
	output cpu_isa_pkg::acc_sel_e   acc_sel_o,
	output logic                    reg_write_o,
	output logic                    store_o,
	output cpu_isa_pkg::branch_e    branch_o
);
	import cpu_isa_pkg::*;

	always_comb
	begin
		mode_o      = INHERENT;
		alu_op_o    = ALU_LD;
		acc_sel_o   = acc_sel_e'(opcode_i[6]);  // b side ops sit in the upper half
		reg_write_o = 1'b0;
		store_o     = 1'b0;
		branch_o    = BR_NONE;
		case (opcode_i)
			LDA, LDB, ADDA, ADDB, SUBA, ANDA, ORA, EORA:
			begin
				mode_o      = IMMEDIATE;
				reg_write_o = 1'b1;
				case (opcode_i)
					ADDA, ADDB: alu_op_o = ALU_ADD;
					SUBA:       alu_op_o = ALU_SUB;
					ANDA:       alu_op_o = ALU_AND;
					ORA:        alu_op_o = ALU_OR;
					EORA:       alu_op_o = ALU_EOR;
					default:    alu_op_o = ALU_LD;
				endcase
			end
			STA, STB:
			begin
				mode_o  = DIRECT;
				store_o = 1'b1;
			end
			BRA:
			begin
				mode_o   = REL8;
				branch_o = BR_ALWAYS;
			end
			BEQ:
			begin
				mode_o   = REL8;
				branch_o = BR_EQ;
			end
			BNE:
			begin
				mode_o   = REL8;
				branch_o = BR_NE;
			end
			default: ;  // nop and anything unknown
		endcase
	end

endmodule

//--- verilog/alu.sv
// 8-bit accumulator ALU with nzvc flag generation, used once inside the core
module alu (
	input  cpu_isa_pkg::alu_op_e op_i,
	input  cpu_bus_pkg::data_t   a_i,
	input  cpu_bus_pkg::data_t   b_i,
	input  logic [3:0]           cc_i,
	output cpu_bus_pkg::data_t   result_o,
	output logic [3:0]           cc_o
);
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;

	localparam int MSB = DATA_W - 1;

	logic [DATA_W:0] wide;  // extra bit holds carry or borrow

	always_comb
	begin
		wide = '0;
		cc_o = cc_i;
		cc_o[FLAG_V] = 1'b0;  // logic ops clear v, keep c
		case (op_i)
			ALU_ADD:
			begin
				wide = {1'b0, a_i} + {1'b0, b_i};
				result_o = wide[MSB:0];
				cc_o[FLAG_C] = wide[DATA_W];
				cc_o[FLAG_V] = (a_i[MSB] == b_i[MSB]) && (result_o[MSB] != a_i[MSB]);
			end
			ALU_SUB:
			begin
				wide = {1'b0, a_i} - {1'b0, b_i};
				result_o = wide[MSB:0];
				cc_o[FLAG_C] = wide[DATA_W];  // borrow
				cc_o[FLAG_V] = (a_i[MSB] != b_i[MSB]) && (result_o[MSB] != a_i[MSB]);
			end
			ALU_AND: result_o = a_i & b_i;
			ALU_OR:  result_o = a_i | b_i;
			ALU_EOR: result_o = a_i ^ b_i;
			default: result_o = b_i;  // load passes the operand
		endcase
		cc_o[FLAG_N] = result_o[MSB];
		cc_o[FLAG_Z] = (result_o == '0);
	end

endmodule

//--- verilog/register_file.sv
// accumulators, program counter and condition codes of the core
module register_file #(
	parameter int ADDR_W = cpu_bus_pkg::ADDR_W
) (
	input  logic                  cpu_clk_i,
	input  logic                  k_reset_i,
	input  cpu_isa_pkg::acc_sel_e acc_sel_i,
	output cpu_bus_pkg::data_t    acc_o,
	input  logic                  reg_wr_i,
	input  cpu_bus_pkg::data_t    result_i,
	input  logic [3:0]            cc_i,
	output logic [3:0]            cc_o,
	input  logic                  pc_inc_i,
	input  logic                  pc_load_i,
	input  logic [ADDR_W-1:0]     pc_next_i,
	output logic [ADDR_W-1:0]     pc_o
);
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;

	data_t acc_a;
	data_t acc_b;
	logic [3:0] cc_q;
	logic [ADDR_W-1:0] pc_q;

	always_ff @(posedge cpu_clk_i or posedge k_reset_i)
	begin
		if (k_reset_i)
		begin
			acc_a <= '0;
			acc_b <= '0;
			cc_q  <= '0;
		end
		else if (reg_wr_i)
		begin
			if (acc_sel_i == ACC_B)
				acc_b <= result_i;
			else
				acc_a <= result_i;
			cc_q <= cc_i;  // flags go with the result
		end
	end

	always_ff @(posedge cpu_clk_i or posedge k_reset_i)
	begin
		if (k_reset_i)
			pc_q <= '0;
		else if (pc_load_i)
			pc_q <= pc_next_i;  // branch or vector wins
		else if (pc_inc_i)
			pc_q <= pc_q + 1'b1;
	end

	assign acc_o = (acc_sel_i == ACC_B) ? acc_b : acc_a;
	assign cc_o  = cc_q;
	assign pc_o  = pc_q;

endmodule

//--- verilog/sequencer.sv
// main state machine of the core and its Wishbone classic master, one access at a time
module sequencer #(
	parameter int ADDR_W = cpu_bus_pkg::ADDR_W
) (
	input  logic                    cpu_clk_i,
	input  logic                    k_reset_i,
	output logic                    wb_cyc_o,
	output logic                    wb_stb_o,
	output logic                    wb_we_o,
	output logic [ADDR_W-1:0]       wb_adr_o,
	output cpu_bus_pkg::data_t      wb_dat_o,
	input  cpu_bus_pkg::data_t      wb_dat_i,
	input  logic                    wb_ack_i,
	output cpu_bus_pkg::data_t      opcode_o,
	output cpu_bus_pkg::data_t      operand_o,
	input  cpu_isa_pkg::addr_mode_e mode_i,
	input  cpu_isa_pkg::branch_e    branch_i,
	input  logic                    store_i,
	input  logic                    reg_write_i,
	input  cpu_bus_pkg::data_t      acc_i,
	input  logic [ADDR_W-1:0]       pc_i,
	input  logic [3:0]              cc_i,
	output logic                    pc_inc_o,
	output logic                    pc_load_o,
	output logic [ADDR_W-1:0]       pc_next_o,
	output logic                    reg_wr_o
);
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;

	typedef enum logic [2:0] {VEC_HI, VEC_LO, FETCH, OPERAND, EXECUTE, STORE} state_e;

	// vector sits at the top of whatever address space is built
	localparam logic [ADDR_W-1:0] VEC_ADDR = RESET_VECTOR[ADDR_W-1:0];

	state_e state_q;
	bus_kind_e kind_q;
	logic cyc_q;
	logic we_q;
	logic [ADDR_W-1:0] adr_q;
	data_t dat_q;
	data_t opcode_q;
	data_t operand_q;
	data_t vec_hi_q;
	logic done;                 // transfer ends this cycle
	logic issue;                // start a transfer on this edge
	logic [ADDR_W-1:0] issue_adr;
	bus_kind_e issue_kind;
	logic taken;
	addr_t vector;
	logic [ADDR_W-1:0] target;

	assign done   = cyc_q & wb_ack_i;
	assign vector = {vec_hi_q, wb_dat_i};
	assign target = pc_i + {{(ADDR_W-DATA_W){operand_q[DATA_W-1]}}, operand_q};

	always_comb
	begin
		issue      = 1'b0;
		issue_adr  = pc_i;
		issue_kind = BUS_FETCH;
		case (state_q)
			VEC_HI:
			begin
				issue      = !cyc_q;
				issue_adr  = VEC_ADDR;
				issue_kind = BUS_VECTOR;
			end
			VEC_LO:
			begin
				issue      = !cyc_q;
				issue_adr  = VEC_ADDR + 1'b1;
				issue_kind = BUS_VECTOR;
			end
			FETCH: issue = !cyc_q;
			OPERAND:
			begin
				issue      = !cyc_q && (mode_i != INHERENT);
				issue_kind = BUS_OPERAND;
			end
			STORE:
			begin
				issue      = !cyc_q;
				issue_adr  = {{(ADDR_W-DATA_W){1'b0}}, operand_q};  // page zero
				issue_kind = BUS_STORE;
			end
			default: ;
		endcase
	end

	always_comb
	begin
		case (branch_i)
			BR_ALWAYS: taken = 1'b1;
			BR_EQ:     taken = cc_i[FLAG_Z];
			BR_NE:     taken = !cc_i[FLAG_Z];
			default:   taken = 1'b0;
		endcase
	end

	always_ff @(posedge cpu_clk_i or posedge k_reset_i)
	begin
		if (k_reset_i)
		begin
			state_q  <= VEC_HI;
			kind_q   <= BUS_FETCH;
			cyc_q    <= 1'b0;
			we_q     <= 1'b0;
			opcode_q <= NOP;
		end
		else
		begin
			if (issue)
			begin
				cyc_q  <= 1'b1;
				we_q   <= (issue_kind == BUS_STORE);
				kind_q <= issue_kind;
			end
			else if (done)
			begin
				cyc_q <= 1'b0;
				we_q  <= 1'b0;
			end
			if (done && kind_q == BUS_FETCH)
				opcode_q <= wb_dat_i;
			case (state_q)
				VEC_HI:  if (done) state_q <= VEC_LO;
				VEC_LO:  if (done) state_q <= FETCH;
				FETCH:   if (done) state_q <= OPERAND;
				OPERAND: if (done || (!cyc_q && mode_i == INHERENT)) state_q <= EXECUTE;
				EXECUTE: state_q <= store_i ? STORE : FETCH;
				STORE:   if (done) state_q <= FETCH;
				default: state_q <= VEC_HI;
			endcase
		end
	end

	always_ff @(posedge cpu_clk_i)
	begin
		if (issue)
		begin
			adr_q <= issue_adr;
			dat_q <= acc_i;  // only driven out on a store
		end
		if (done)
		begin
			case (kind_q)
				BUS_OPERAND: operand_q <= wb_dat_i;
				BUS_VECTOR:  if (state_q == VEC_HI) vec_hi_q <= wb_dat_i;
				default: ;
			endcase
		end
	end

	assign pc_inc_o  = done && (kind_q == BUS_FETCH || kind_q == BUS_OPERAND);
	assign pc_load_o = (state_q == VEC_LO && done) || (state_q == EXECUTE && taken);
	assign pc_next_o = (state_q == EXECUTE) ? target : vector[ADDR_W-1:0];
	assign reg_wr_o  = (state_q == EXECUTE) && reg_write_i;

	assign wb_cyc_o  = cyc_q;
	assign wb_stb_o  = cyc_q;  // single transfer per cycle
	assign wb_we_o   = we_q;
	assign wb_adr_o  = adr_q;
	assign wb_dat_o  = dat_q;
	assign opcode_o  = opcode_q;
	assign operand_o = operand_q;

endmodule

//--- verilog/cpu_top.sv
// top level of the 6809 subset core, a Wishbone classic master exposing nzvc
module cpu_top #(
	parameter int ADDR_W = cpu_bus_pkg::ADDR_W
) (
	input  logic               cpu_clk_i,
	input  logic               k_reset_i,
	output logic               wb_cyc_o,
	output logic               wb_stb_o,
	output logic               wb_we_o,
	output logic [ADDR_W-1:0]  wb_adr_o,
	output cpu_bus_pkg::data_t wb_dat_o,
	input  cpu_bus_pkg::data_t wb_dat_i,
	input  logic               wb_ack_i,
	output logic [3:0]         cc_o
);
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;

	data_t opcode;
	data_t operand;
	addr_mode_e mode;
	alu_op_e alu_op;
	acc_sel_e acc_sel;
	logic reg_write;
	logic store;
	branch_e branch;
	data_t acc;
	data_t alu_result;
	logic [3:0] alu_cc;
	logic [3:0] cc;
	logic [ADDR_W-1:0] pc;
	logic [ADDR_W-1:0] pc_next;
	logic pc_inc;
	logic pc_load;
	logic reg_wr;

	sequencer #(.ADDR_W(ADDR_W)) sequencer_i (
		.cpu_clk_i(cpu_clk_i), .k_reset_i(k_reset_i),
		.wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o),
		.wb_adr_o(wb_adr_o), .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i),
		.opcode_o(opcode), .operand_o(operand),
		.mode_i(mode), .branch_i(branch), .store_i(store), .reg_write_i(reg_write),
		.acc_i(acc), .pc_i(pc), .cc_i(cc),
		.pc_inc_o(pc_inc), .pc_load_o(pc_load), .pc_next_o(pc_next), .reg_wr_o(reg_wr)
	);

	opcode_decoder decoder_i (
		.opcode_i(opcode), .mode_o(mode), .alu_op_o(alu_op), .acc_sel_o(acc_sel),
		.reg_write_o(reg_write), .store_o(store), .branch_o(branch)
	);

	alu alu_i (
		.op_i(alu_op), .a_i(acc), .b_i(operand), .cc_i(cc),
		.result_o(alu_result), .cc_o(alu_cc)
	);

	register_file #(.ADDR_W(ADDR_W)) regs_i (
		.cpu_clk_i(cpu_clk_i), .k_reset_i(k_reset_i),
		.acc_sel_i(acc_sel), .acc_o(acc),
		.reg_wr_i(reg_wr), .result_i(alu_result), .cc_i(alu_cc), .cc_o(cc),
		.pc_inc_i(pc_inc), .pc_load_i(pc_load), .pc_next_i(pc_next), .pc_o(pc)
	);

	assign cc_o = cc;

endmodule

//--- tb/cpu_sva.sv
// Wishbone classic master protocol checks, bound into the sequencer by the testbench
module cpu_sva #(
	parameter int ADDR_W = 16
) (
	input logic              cpu_clk_i,
	input logic              k_reset_i,
	input logic              wb_cyc_i,
	input logic              wb_stb_i,
	input logic              wb_we_i,
	input logic [ADDR_W-1:0] wb_adr_i,
	input logic [7:0]        wb_wdat_i,
	input logic              wb_ack_i
);
	timeunit 1ns;
	timeprecision 100ps;

	int unsigned fail_count = 0;  // read back at the end of the run

	// cycle closes on the edge after the acked one
	cycle_ends_after_ack: assert property (@(posedge cpu_clk_i) disable iff (k_reset_i)
		(wb_stb_i && wb_ack_i) |=> (!wb_cyc_i && !wb_stb_i))
	else
	begin
		$error("cyc or stb still high after the acked cycle");
		fail_count++;
	end

	// request held until the slave answers
	request_stable: assert property (@(posedge cpu_clk_i) disable iff (k_reset_i)
		(wb_stb_i && !wb_ack_i) |=> ($stable(wb_adr_i) && $stable(wb_we_i)
		&& $stable(wb_wdat_i)))
	else
	begin
		$error("adr, we or dat changed while waiting for ack");
		fail_count++;
	end

	idle_in_reset: assert property (@(posedge cpu_clk_i) k_reset_i |-> !wb_cyc_i)
	else
	begin
		$error("cyc high during reset");
		fail_count++;
	end

endmodule

//--- tb/tb_top.sv
// testbench for cpu_top: runs short programs from a table against a Wishbone memory model
module tb_top;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 5;
	localparam int CYCLE_LIMIT = 200;             // per test, until the first store
	localparam int N_ROWS = 17;
	localparam int N_TESTS = 2 * N_ROWS;          // zero waits first, then random waits
	localparam int WATCHDOG_CYCLES = N_TESTS * CYCLE_LIMIT * 4;
	localparam logic [31:0] SEED = 32'he58f_074c;

	// program bytes run from the vector upward, then the first store they must make
	typedef struct packed {
		logic [15:0] vec;
		logic [63:0] prog;
		logic [15:0] adr;
		logic [7:0]  dat;
		logic [3:0]  cc;                          // n z v c
	} row_t;

	row_t rows [N_ROWS] = '{
		'{16'h4000, 64'h8635_8680_9710_1212, 16'h0010, 8'h80, 4'h8},  // lda
		'{16'h4100, 64'h8635_8B4B_9711_1212, 16'h0011, 8'h80, 4'hA},  // adda overflow
		'{16'h8123, 64'h8620_8030_9712_1212, 16'h0012, 8'hF0, 4'h9},  // suba borrow
		'{16'h0200, 64'h8680_8001_9713_1212, 16'h0013, 8'h7F, 4'h2},  // suba overflow
		'{16'h7FF0, 64'h863C_84C3_9714_1212, 16'h0014, 8'h00, 4'h4},  // anda to zero
		'{16'hC000, 64'h863C_8AC0_9715_1212, 16'h0015, 8'hFC, 4'h8},  // ora
		'{16'h1234, 64'h86FF_880F_9716_1212, 16'h0016, 8'hF0, 4'h8},  // eora
		'{16'hABCD, 64'h86FF_8B01_9717_1212, 16'h0017, 8'h00, 4'h5},  // adda carry out
		'{16'h0100, 64'h86FF_8B01_8A81_9718, 16'h0018, 8'h81, 4'h9},  // ora keeps carry
		'{16'h5A5A, 64'h8611_C670_CB25_D720, 16'h0020, 8'h95, 4'hA},  // addb, stb
		'{16'h3000, 64'h8611_C670_CB25_9721, 16'h0021, 8'h11, 4'hA},  // a untouched by b ops
		'{16'hE000, 64'h8600_2702_9730_9731, 16'h0031, 8'h00, 4'h4},  // beq taken
		'{16'h2468, 64'h8605_2702_9730_9731, 16'h0030, 8'h05, 4'h0},  // beq falls through
		'{16'h9000, 64'h8605_2602_9730_9731, 16'h0031, 8'h05, 4'h0},  // bne taken
		'{16'h0F00, 64'h8600_2602_9730_9731, 16'h0030, 8'h00, 4'h4},  // bne falls through
		'{16'h6001, 64'h8680_2002_9730_9731, 16'h0031, 8'h80, 4'h8},  // bra
		'{16'hF000, 64'h1201_8642_9733_1212, 16'h0033, 8'h42, 4'h0}   // nop, unknown op
	};

	logic cpu_clk;
	logic k_reset = 1'b0;                         // raised on the first falling edge
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [15:0] wb_adr;
	logic [7:0] dut_dat;
	logic [7:0] mem_dat = 8'h00;
	logic wb_ack = 1'b0;
	logic [3:0] cc_flags;

	logic [7:0] mem [0:65535];
	logic [31:0] rand_state = SEED;
	logic random_waits = 1'b0;
	logic busy;                                   // a request is counting down its wait
	int unsigned wait_left;
	int unsigned n_reads;
	logic [15:0] read_adr [3];
	logic write_seen;
	logic [15:0] write_adr;
	logic [7:0] write_dat;
	int errors = 0;
	int failed_tests = 0;

	cpu_top dut_i (
		.cpu_clk_i(cpu_clk), .k_reset_i(k_reset),
		.wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
		.wb_dat_o(dut_dat), .wb_dat_i(mem_dat), .wb_ack_i(wb_ack), .cc_o(cc_flags)
	);

	bind sequencer cpu_sva #(.ADDR_W(ADDR_W)) sva_i (
		.cpu_clk_i(cpu_clk_i), .k_reset_i(k_reset_i), .wb_cyc_i(wb_cyc_o),
		.wb_stb_i(wb_stb_o), .wb_we_i(wb_we_o), .wb_adr_i(wb_adr_o),
		.wb_wdat_i(wb_dat_o), .wb_ack_i(wb_ack_i)
	);

	function automatic logic [31:0] next_random(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic load_program(input row_t r);
		for (int a = 0; a < 65536; a++)
			mem[a] = 8'(a) ^ 8'(a >> 8);          // background from both address halves
		mem[16'hFFFE] = r.vec[15:8];
		mem[16'hFFFF] = r.vec[7:0];
		for (int i = 0; i < 8; i++)
			mem[r.vec + 16'(i)] = r.prog[63 - 8*i -: 8];
	endtask

	task automatic run_test(input int t);
		row_t r;
		int cycles;
		int errors_before;
		r = rows[t % N_ROWS];
		errors_before = errors;
		@(negedge cpu_clk);
		k_reset = 1'b1;
		random_waits = (t >= N_ROWS);
		load_program(r);
		repeat (RESET_CYCLES) @(negedge cpu_clk);
		k_reset = 1'b0;
		cycles = 0;
		while (!write_seen && cycles < CYCLE_LIMIT)
		begin
			@(posedge cpu_clk);
			cycles++;
		end
		@(negedge cpu_clk);                       // flags are settled here
		if (!write_seen)
		begin
			$display("test %0d: no store cycle within %0d clock cycles", t, CYCLE_LIMIT);
			errors++;
		end
		else
		begin
			check_value("wb_adr_o (first read)", read_adr[0], 16'hFFFE);
			check_value("wb_adr_o (second read)", read_adr[1], 16'hFFFF);
			check_value("wb_adr_o (first fetch)", read_adr[2], r.vec);
			check_value("wb_adr_o (store)", write_adr, r.adr);
			check_value("wb_dat_o (store)", write_dat, r.dat);
			check_value("cc_o", cc_flags, r.cc);
		end
		if (errors != errors_before)
			failed_tests++;
		$display("test %2d  vector %h  %s waits  %s", t, r.vec,
			random_waits ? "random" : "zero", (errors == errors_before) ? "ok" : "mismatch");
	endtask

	initial
	begin
		cpu_clk = 1'b0;
		forever #(CLK_PERIOD / 2) cpu_clk = ~cpu_clk;
	end

	// memory answers each strobe after 0 to 3 wait cycles
	always @(negedge cpu_clk)
	begin
		if (k_reset)
		begin
			wb_ack <= 1'b0;
			busy = 1'b0;
			n_reads = 0;
			write_seen = 1'b0;
		end
		else if (wb_ack)
			wb_ack <= 1'b0;                       // cyc drops on the acked edge
		else if (wb_stb)
		begin
			if (!busy)
			begin
				rand_state = next_random(rand_state);
				wait_left = random_waits ? int'(rand_state[31:30]) : 0;
				busy = 1'b1;
			end
			if (wait_left == 0)
			begin
				busy = 1'b0;
				wb_ack <= 1'b1;
				if (wb_we && !write_seen)
				begin
					write_seen = 1'b1;
					write_adr = wb_adr;
					write_dat = dut_dat;
				end
				else if (!wb_we)
				begin
					mem_dat <= mem[wb_adr];
					if (n_reads < 3)
						read_adr[n_reads] = wb_adr;
					n_reads++;
				end
			end
			else
				wait_left--;
		end
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog: run still busy after %0d clock cycles", WATCHDOG_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

	initial
	begin
		for (int t = 0; t < N_TESTS; t++)
			run_test(t);
		if (dut_i.sequencer_i.sva_i.fail_count != 0)
			$display("bus protocol assertions failed %0d times",
				dut_i.sequencer_i.sva_i.fail_count);
		$display("tests: %0d run, %0d passed, %0d failed, %0d errors", N_TESTS,
			N_TESTS - failed_tests, failed_tests, errors);
		if (failed_tests == 0 && dut_i.sequencer_i.sva_i.fail_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- tb.f
verilog/cpu_isa_pkg.sv
verilog/cpu_bus_pkg.sv
verilog/opcode_decoder.sv
verilog/alu.sv
verilog/register_file.sv
verilog/sequencer.sv
verilog/cpu_top.sv
tb/cpu_sva.sv
tb/tb_top.sv

//--- Makefile
# Verilator build and run of the 6809 subset core testbench

VERILATOR ?= verilator
TOP       ?= tb_top
RTL_TOP   ?= cpu_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal
RUNFLAGS  ?= +verilator+error+limit+100
PASS_MSG  ?= RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
